// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // architectural register width
  localparam int xlen = 32;

  // data, pc and instruction words
  typedef logic [xlen-1:0] word_t;

  // register index, wide enough for x0..x31
  typedef logic [4:0] reg_addr_t;

  // rv32i major opcodes
  typedef enum logic [6:0] {
    op_load     = 7'b00_000_11,
    op_store    = 7'b01_000_11,
    op_branch   = 7'b11_000_11,
    op_jalr     = 7'b11_001_11,
    op_misc_mem = 7'b00_011_11,
    op_jal      = 7'b11_011_11,
    op_reg_imm  = 7'b00_100_11,
    op_reg_reg  = 7'b01_100_11,
    op_environ  = 7'b11_100_11,
    op_auipc    = 7'b00_101_11,
    op_lui      = 7'b01_101_11
  } opcode_e;

  // operations the alu can perform
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    // forwards operand b, used by lui
    alu_pass_b = 4'd10
  } alu_op_e;

  // branch conditions share the funct3 codes of the branch instructions
  // br_none sits on one of the two unused codes
  typedef enum logic [2:0] {
    br_eq   = 3'b000,
    br_ne   = 3'b001,
    br_none = 3'b010,
    br_lt   = 3'b100,
    br_ge   = 3'b101,
    br_ltu  = 3'b110,
    br_geu  = 3'b111
  } branch_e;

endpackage

`default_nettype wire

// File: source/rv_decoder.sv
`default_nettype none

module rv_decoder
  import rv_pkg::*;
(
  input  word_t     insn,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output word_t     imm,
  output alu_op_e   alu_op,
  output logic      b_sel_imm,
  output logic      reg_we,
  output branch_e   branch,
  output logic      is_ecall,
  output logic      illegal
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  opcode_e    opcode;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;

  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  // sign-extended immediates, b-type already has its zero lsb
  assign imm_i = {{(xlen - 12){insn[31]}}, insn[31:20]};
  assign imm_b = {{(xlen - 13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    imm       = imm_i;
    alu_op    = alu_add;
    b_sel_imm = 1'b0;
    reg_we    = 1'b0;
    branch    = br_none;
    is_ecall  = 1'b0;
    illegal   = 1'b0;

    case (opcode)
      op_lui: begin
        imm       = imm_u;
        alu_op    = alu_pass_b;
        b_sel_imm = 1'b1;
        reg_we    = 1'b1;
      end

      op_reg_imm: begin
        b_sel_imm = 1'b1;
        case (funct3)
          3'b000: alu_op = alu_add;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b110: alu_op = alu_or;
          3'b111: alu_op = alu_and;
          // shifts carry funct7 in the upper immediate bits
          3'b001: begin
            alu_op  = alu_sll;
            illegal = (funct7 != 7'b0000000);
          end
          default: begin
            alu_op  = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
            illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
        reg_we = !illegal;
      end

      op_reg_reg: begin
        case (funct3)
          3'b000: alu_op = (funct7 == 7'b0100000) ? alu_sub : alu_add;
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: alu_op = (funct7 == 7'b0100000) ? alu_sra : alu_srl;
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // only add/sub and srl/sra have an alternate funct7
        if (funct3 == 3'b000 || funct3 == 3'b101) begin
          illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end else begin
          illegal = (funct7 != 7'b0000000);
        end
        reg_we = !illegal;
      end

      op_branch: begin
        imm = imm_b;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          illegal = 1'b1;
        end else begin
          branch = branch_e'(funct3);
        end
      end

      op_environ: begin
        // ecall only, ebreak and csr accesses are not supported
        if (insn[31:7] == '0) begin
          is_ecall = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      // loads, stores, jumps, auipc and fence are not executed
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e alu_op,
  output word_t   result
);

  localparam int shamt_w = $clog2(xlen);

  logic [shamt_w-1:0] shamt;
  word_t              sum;
  word_t              diff;
  logic               lt_signed;
  logic               lt_unsigned;

  // shift amount comes from the low bits of b only
  assign shamt = b[shamt_w-1:0];

  // single adder and subtractor shared by every form
  assign sum  = a + b;
  assign diff = a - b;

  assign lt_signed   = ($signed(a) < $signed(b));
  assign lt_unsigned = (a < b);

  always_comb begin
    case (alu_op)
      alu_add: result = sum;
      alu_sub: result = diff;
      alu_sll: result = a << shamt;
      alu_slt: begin
        result = '0;
        result[0] = lt_signed;
      end
      alu_sltu: begin
        result = '0;
        result[0] = lt_unsigned;
      end
      alu_xor: result = a ^ b;
      alu_srl: result = a >> shamt;
      // arithmetic shift keeps the sign of a
      alu_sra: result = word_t'($signed(a) >>> shamt);
      alu_or: result = a | b;
      alu_and: result = a & b;
      alu_pass_b: result = b;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`default_nettype none

module rv_regfile
  import rv_pkg::*;
#(
  parameter int num_regs = 32
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      we,
  input  reg_addr_t rd,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [num_regs];

  // x0 and indices beyond the last register read as zero
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1 != '0 && int'(rs1) < num_regs) begin
      rs1_data = regs[rs1];
    end
    if (rs2 != '0 && int'(rs2) < num_regs) begin
      rs2_data = regs[rs2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we && rd != '0 && int'(rd) < num_regs) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_pc_unit.sv
`default_nettype none

module rv_pc_unit
  import rv_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic    clk,
  input  logic    rst,
  input  branch_e branch,
  input  logic    is_ecall,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  input  word_t   imm,
  output word_t   pc,
  output logic    halt
);

  logic  taken;
  word_t pc_next;

  // branch compare, br_none never takes
  always_comb begin
    case (branch)
      br_eq:   taken = (rs1_data == rs2_data);
      br_ne:   taken = (rs1_data != rs2_data);
      br_lt:   taken = ($signed(rs1_data) < $signed(rs2_data));
      br_ge:   taken = ($signed(rs1_data) >= $signed(rs2_data));
      br_ltu:  taken = (rs1_data < rs2_data);
      br_geu:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  // b-type offset is already in bytes
  assign pc_next = taken ? (pc + imm) : (pc + word_t'(4));

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      // ecall stops here and pc keeps its address
      if (is_ecall) begin
        halt <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core.sv
`default_nettype none

module rv_core
  import rv_pkg::*;
#(
  parameter int    num_regs = 32,
  parameter word_t reset_pc = '0
) (
  input  logic      clk,
  input  logic      rst,
  input  word_t     insn,
  output word_t     pc,
  output logic      halt,
  output logic      illegal,
  output logic      retire_valid,
  output word_t     retire_pc,
  output reg_addr_t retire_rd,
  output logic      retire_we,
  output word_t     retire_data
);

  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  word_t     imm;
  alu_op_e   alu_op;
  logic      b_sel_imm;
  logic      reg_we;
  branch_e   branch;
  logic      is_ecall;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_b;
  word_t     result;
  logic      active;

  rv_decoder i_rv_decoder (
    .insn      (insn),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .alu_op    (alu_op),
    .b_sel_imm (b_sel_imm),
    .reg_we    (reg_we),
    .branch    (branch),
    .is_ecall  (is_ecall),
    .illegal   (illegal)
  );

  assign alu_b = b_sel_imm ? imm : rs2_data;

  rv_alu i_rv_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (result)
  );

  // a halted core must not keep writing the register file
  rv_regfile #(
    .num_regs (num_regs)
  ) i_rv_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we && !halt),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd_data  (result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_pc_unit #(
    .reset_pc (reset_pc)
  ) i_rv_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .branch   (branch),
    .is_ecall (is_ecall),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .pc       (pc),
    .halt     (halt)
  );

  // trace describes the instruction retiring at the next edge
  assign active       = !rst && !halt;
  assign retire_valid = active;
  assign retire_pc    = active ? pc : '0;
  assign retire_rd    = active ? rd : '0;
  assign retire_we    = active && reg_we;
  assign retire_data  = active ? result : '0;

endmodule

`default_nettype wire

// File: testbench/rv_core_tb.sv
`default_nettype none

module rv_core_tb
  import rv_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t reset_pc = '0;
  localparam int mem_words = 256;
  localparam word_t ecall_insn = 32'h0000_0073;

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  word_t     insn;
  word_t     pc;
  logic      halt;
  logic      illegal;
  logic      retire_valid;
  word_t     retire_pc;
  reg_addr_t retire_rd;
  logic      retire_we;
  word_t     retire_data;

  word_t imem [mem_words];
  word_t mregs [32];
  word_t mpc;
  int    prog_len;
  int    errors;
  int    checks;

  always #5 clk = ~clk;

  // instruction memory answers in the same cycle
  assign insn = imem[pc[9:2]];

  rv_core #(
    .num_regs (32),
    .reset_pc (reset_pc)
  ) i_rv_core (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .illegal      (illegal),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data)
  );

  function automatic word_t encode_imm(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                       logic [11:0] imm);
    return {imm, rs1, f3, rd, op_reg_imm};
  endfunction

  function automatic word_t encode_reg(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                       reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, op_reg_reg};
  endfunction

  function automatic word_t encode_branch(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                          logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t encode_lui(reg_addr_t rd, logic [19:0] upper);
    return {upper, rd, op_lui};
  endfunction

  // expected result of an arithmetic instruction, alt selects sub and sra
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // reference model of one instruction at mpc
  task automatic model_step(input word_t ins, output logic we, output word_t data,
                            output logic bad, output logic is_halt, output word_t next_pc);
    logic [2:0] f3;
    logic [6:0] f7;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    f3 = ins[14:12];
    f7 = ins[31:25];
    a = mregs[ins[19:15]];
    b = mregs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    we = 1'b0;
    data = '0;
    bad = 1'b0;
    is_halt = 1'b0;
    next_pc = mpc + 4;
    case (ins[6:0])
      op_lui: begin
        we = 1'b1;
        data = {ins[31:12], 12'b0};
      end
      op_reg_imm: begin
        bad = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
        we = !bad;
        data = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
      end
      op_reg_reg: begin
        bad = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        we = !bad;
        data = alu_ref(f3, f7 == 7'h20, a, b);
      end
      op_branch: begin
        bad = (f3 == 3'd2 || f3 == 3'd3);
        if (!bad && branch_ref(f3, a, b)) begin
          next_pc = mpc + imm_b;
        end
      end
      op_environ: begin
        is_halt = (ins[31:7] == '0);
        bad = !is_halt;
      end
      default: bad = 1'b1;
    endcase
  endtask

  task automatic load_nops;
    // addi x0 with the word index as immediate
    foreach (imem[i]) begin
      imem[i] = {12'(i), 5'd0, 3'b000, 5'd0, op_reg_imm};
    end
    prog_len = 0;
  endtask

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic apply_reset;
    @(posedge clk);
    rst <= 1'b1;
    repeat (15) @(posedge clk);
    @(negedge clk);
    check("retire_valid", retire_valid, 0);
    check("halt", halt, 0);
    check("pc", pc, reset_pc);
    @(posedge clk);
    rst <= 1'b0;
    foreach (mregs[i]) begin
      mregs[i] = '0;
    end
    mpc = reset_pc;
  endtask

  task automatic wait_halt;
    int cycles;
    cycles = 0;
    while (!halt) begin
      if (cycles == 4) begin
        $display("timeout: halt did not rise after ecall");
        errors++;
        return;
      end
      @(negedge clk);
      cycles++;
    end
    check("halt_cycles", cycles, 1);
  endtask

  // steps the model in lockstep with the trace until ecall
  task automatic run_program(input int limit);
    int    cycles;
    logic  we;
    word_t data;
    logic  bad;
    logic  is_halt;
    word_t next_pc;
    word_t ins;
    cycles = 0;
    is_halt = 1'b0;
    while (!is_halt) begin
      @(negedge clk);
      if (cycles == limit) begin
        $display("timeout: program did not reach ecall within %0d cycles", limit);
        errors++;
        return;
      end
      cycles++;
      ins = imem[mpc[9:2]];
      model_step(ins, we, data, bad, is_halt, next_pc);
      check("retire_valid", retire_valid, 1);
      check("retire_pc", retire_pc, mpc);
      check("illegal", illegal, bad);
      check("retire_we", retire_we, we);
      if (we) begin
        check("retire_rd", retire_rd, ins[11:7]);
        check("retire_data", retire_data, data);
        if (ins[11:7] != 5'd0) begin
          mregs[ins[11:7]] = data;
        end
      end
      if (!is_halt) begin
        mpc = next_pc;
      end
    end
    wait_halt();
  endtask

  task automatic reset_values;
    load_nops();
    apply_reset();
    @(negedge clk);
    check("pc", pc, reset_pc);
    check("halt", halt, 0);
    check("illegal", illegal, 0);
  endtask

  task automatic reg_imm_ops;
    int          i;
    logic [2:0]  f3;
    logic [11:0] imm;
    load_nops();
    for (i = 1; i < 8; i++) begin
      emit(encode_imm(3'd0, 5'(i), 5'd0, 12'($urandom)));
    end
    for (i = 0; i < 40; i++) begin
      f3 = 3'($urandom_range(7, 0));
      imm = 12'($urandom);
      // shifts carry funct7 in the upper immediate bits
      if (f3 == 3'd1) begin
        imm[11:5] = 7'h00;
      end else if (f3 == 3'd5) begin
        imm[11:5] = $urandom_range(1, 0) ? 7'h20 : 7'h00;
      end
      emit(encode_imm(f3, 5'($urandom_range(15, 1)), 5'($urandom_range(15, 0)), imm));
    end
    emit(ecall_insn);
    apply_reset();
    run_program(200);
  endtask

  task automatic reg_reg_ops;
    int i;
    load_nops();
    for (i = 1; i < 7; i++) begin
      emit(encode_lui(5'(i), 20'($urandom)));
      emit(encode_imm(3'd0, 5'(i), 5'(i), 12'($urandom)));
    end
    // x7 negative, x8 small positive
    emit(encode_lui(5'd7, 20'h80000));
    emit(encode_imm(3'd0, 5'd8, 5'd0, 12'd9));
    for (i = 0; i < 8; i++) begin
      emit(encode_reg(7'h00, 3'(i), 5'd9, 5'd7, 5'd8));
      emit(encode_reg(7'h00, 3'(i), 5'd10, 5'd8, 5'd7));
      emit(encode_reg(7'h00, 3'(i), 5'd11, 5'($urandom_range(6, 1)), 5'($urandom_range(6, 1))));
      if (i == 0 || i == 5) begin
        emit(encode_reg(7'h20, 3'(i), 5'd12, 5'd7, 5'd8));
        emit(encode_reg(7'h20, 3'(i), 5'd13, 5'($urandom_range(6, 1)), 5'd2));
      end
    end
    // write to x0 is dropped, so the add returns x2
    emit(encode_imm(3'd0, 5'd0, 5'd1, 12'h123));
    emit(encode_reg(7'h00, 3'd0, 5'd14, 5'd0, 5'd2));
    emit(ecall_insn);
    apply_reset();
    run_program(100);
  endtask

  task automatic branch_ops;
    int         i;
    logic [2:0] conds [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    int         start [6] = '{0, 3, -2, 2, 0, 3};
    int         bound [6] = '{1, 0, 1, 0, 2, 1};
    int         step [6] = '{1, -1, 1, -1, 1, -1};
    load_nops();
    emit(encode_imm(3'd0, 5'd1, 5'd0, 12'd5));
    emit(encode_imm(3'd0, 5'd2, 5'd0, 12'hffd));
    emit(encode_imm(3'd0, 5'd3, 5'd0, 12'd5));
    for (i = 0; i < 6; i++) begin
      // forward, a taken branch skips the marker addi
      emit(encode_branch(conds[i], 5'd1, 5'd2, 13'd8));
      emit(encode_imm(3'd0, 5'd10, 5'd10, 12'd1));
      emit(encode_branch(conds[i], 5'd2, 5'd1, 13'd8));
      emit(encode_imm(3'd0, 5'd10, 5'd10, 12'd1));
      emit(encode_branch(conds[i], 5'd1, 5'd3, 13'd8));
      emit(encode_imm(3'd0, 5'd10, 5'd10, 12'd1));
      // backward loop, exits by falling through
      emit(encode_imm(3'd0, 5'd4, 5'd0, 12'(start[i])));
      emit(encode_imm(3'd0, 5'd5, 5'd0, 12'(bound[i])));
      emit(encode_imm(3'd0, 5'd4, 5'd4, 12'(step[i])));
      emit(encode_branch(conds[i], 5'd4, 5'd5, 13'h1ffc));
    end
    emit(ecall_insn);
    apply_reset();
    run_program(150);
  endtask

  task automatic ecall_halt;
    int i;
    load_nops();
    emit(encode_imm(3'd0, 5'd1, 5'd0, 12'd1));
    emit(encode_imm(3'd0, 5'd2, 5'd1, 12'd2));
    emit(ecall_insn);
    emit(encode_imm(3'd0, 5'd3, 5'd0, 12'd7));
    apply_reset();
    run_program(20);
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      check("pc", pc, mpc);
      check("halt", halt, 1);
      check("retire_valid", retire_valid, 0);
      check("retire_we", retire_we, 0);
    end
  endtask

  task automatic illegal_insns;
    load_nops();
    emit(encode_imm(3'd0, 5'd1, 5'd0, 12'd7));
    // sw x1, 0(x0)
    emit({7'b0, 5'd1, 5'd0, 3'b010, 5'd0, op_store});
    // mul encoding, funct7 not in rv32i
    emit(encode_reg(7'h01, 3'd0, 5'd2, 5'd1, 5'd1));
    // slli carrying the srai funct7
    emit(encode_imm(3'd1, 5'd4, 5'd1, 12'h405));
    emit(encode_reg(7'h00, 3'd0, 5'd3, 5'd2, 5'd1));
    emit(ecall_insn);
    apply_reset();
    run_program(20);
  endtask

  initial begin
    void'($urandom(32'hda92_8b47));
    errors = 0;
    checks = 0;
    reset_values();
    reg_imm_ops();
    reg_reg_ops();
    branch_ops();
    ecall_halt();
    illegal_insns();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_pc_unit.sv
source/rv_core.sv
testbench/rv_core_tb.sv
